/* common/snn_pkg.sv */
// ====================
// shared widths, table size, FIFO depth
// and the synapse event carried by the FIFO
// ====================

package snn_pkg;

    // source neuron address, as in the spike stream
    localparam int addr_w = 12;

    // connection table size and index width
    localparam int n_syn = 5;
    localparam int idx_w = 3;

    // signed Q8.8 weight
    localparam int weight_w = 16;

    // timestep sum width
    // five Q8.8 weights need at most 19 bits, one spare
    localparam int sum_w = 20;

    // default event FIFO depth
    localparam int fifo_depth = 8;

    // FIFO payload, 20 bits
    // step set means timestep marker, idx and weight unused then
    typedef struct packed {
        logic                       step;
        logic [idx_w-1:0]           idx;
        logic signed [weight_w-1:0] weight;
    } syn_event_t;

endpackage

/* logic/synapse_match.sv */
// ====================
// connection table, address match,
// per-timestep duplicate filter, event output
// ====================
`timescale 1ns/1ps

module synapse_match (
    input  logic                           clear_mac25,
    input  logic                           arst_n,
    input  logic                           cfg_valid,
    input  logic [snn_pkg::idx_w-1:0]      cfg_index,
    input  logic [snn_pkg::addr_w-1:0]     cfg_addr,
    input  logic [snn_pkg::weight_w-1:0]   cfg_weight,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [snn_pkg::addr_w-1:0]     in_addr,
    input  logic                           in_step,
    output logic                           ev_valid,
    input  logic                           ev_ready,
    output snn_pkg::syn_event_t            ev
);

    // table contents, enable bits and seen mask
    logic [snn_pkg::addr_w-1:0]   tbl_addr   [snn_pkg::n_syn];
    logic [snn_pkg::weight_w-1:0] tbl_weight [snn_pkg::n_syn];
    logic [snn_pkg::n_syn-1:0]    tbl_en;
    logic [snn_pkg::n_syn-1:0]    seen;

    logic                         hit;
    logic [snn_pkg::idx_w-1:0]    hit_idx;
    logic                         accept;
    logic                         produce;

    // parallel compare, scan from the top so the lowest index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = snn_pkg::n_syn - 1; i >= 0; i--) begin
            if (tbl_en[i] && (tbl_addr[i] == in_addr)) begin
                hit     = 1'b1;
                hit_idx = snn_pkg::idx_w'(i);
            end
        end
    end

    // output register free or draining this cycle
    assign in_ready = !ev_valid || ev_ready;
    assign accept   = in_valid && in_ready;

    // markers always pass, spikes only on first hit this timestep
    assign produce = accept && (in_step || (hit && !seen[hit_idx]));

    // config write, takes effect at the next edge
    always_ff @(posedge clear_mac25) begin
        if (cfg_valid && (cfg_index < snn_pkg::n_syn)) begin
            tbl_addr[cfg_index]   <= cfg_addr;
            tbl_weight[cfg_index] <= cfg_weight;
        end
    end

    always_ff @(posedge clear_mac25 or negedge arst_n) begin
        if (!arst_n) begin
            tbl_en   <= '0;
            seen     <= '0;
            ev_valid <= 1'b0;
        end else begin
            if (cfg_valid && (cfg_index < snn_pkg::n_syn)) begin
                tbl_en[cfg_index] <= 1'b1;
            end
            // marker closes the timestep
            if (accept && in_step) begin
                seen <= '0;
            end else if (produce) begin
                seen[hit_idx] <= 1'b1;
            end
            // hold while the downstream stalls
            if (in_ready) begin
                ev_valid <= produce;
            end
        end
    end

    // event payload
    always_ff @(posedge clear_mac25) begin
        if (produce) begin
            ev.step   <= in_step;
            ev.idx    <= in_step ? '0 : hit_idx;
            ev.weight <= in_step ? '0 : tbl_weight[hit_idx];
        end
    end

endmodule

/* logic/event_fifo.sv */
// ====================
// synchronous event FIFO
// valid/ready on both sides
// ====================
`timescale 1ns/1ps

module event_fifo #(
    parameter int DEPTH = snn_pkg::fifo_depth
) (
    input  logic                clear_mac25,
    input  logic                arst_n,
    input  logic                wr_valid,
    output logic                wr_ready,
    input  snn_pkg::syn_event_t wr_data,
    output logic                rd_valid,
    input  logic                rd_ready,
    output snn_pkg::syn_event_t rd_data
);

    localparam int ptr_w = $clog2(DEPTH);
    localparam int cnt_w = $clog2(DEPTH + 1);

    // storage
    snn_pkg::syn_event_t mem [DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign rd_valid = (count != '0);
    // when full, a read in the same cycle frees a slot
    assign wr_ready = (count != cnt_w'(DEPTH)) || rd_ready;

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    // head of queue
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clear_mac25) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at DEPTH, any depth works
    always_ff @(posedge clear_mac25 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy, unchanged on simultaneous push and pop
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* mac/mac_accum.sv */
// ====================
// weight accumulator, fired mask
// and timestep result register
// ====================
`timescale 1ns/1ps

module mac_accum (
    input  logic                               clear_mac25,
    input  logic                               arst_n,
    input  logic                               ev_valid,
    output logic                               ev_ready,
    input  snn_pkg::syn_event_t                ev,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic signed [snn_pkg::sum_w-1:0]   out_sum,
    output logic [snn_pkg::n_syn-1:0]          out_mask
);

    // running values of the open timestep
    logic signed [snn_pkg::sum_w-1:0] run_sum;
    logic [snn_pkg::n_syn-1:0]        run_mask;

    logic signed [snn_pkg::sum_w-1:0] weight_ext;
    logic [snn_pkg::n_syn-1:0]        idx_bit;
    logic                             pop;
    logic                             pop_spike;
    logic                             pop_step;

    // Q8.8 weight widened with its sign bit
    assign weight_ext = {{(snn_pkg::sum_w - snn_pkg::weight_w){ev.weight[snn_pkg::weight_w-1]}},
                         ev.weight};

    // one-hot of the fired synapse
    assign idx_bit = snn_pkg::n_syn'(1) << ev.idx;

    // spikes always taken
    // markers wait for a free result register
    assign ev_ready = !ev.step || !out_valid || out_ready;

    assign pop       = ev_valid && ev_ready;
    assign pop_spike = pop && !ev.step;
    assign pop_step  = pop && ev.step;

    // accumulation, restarts on every marker
    always_ff @(posedge clear_mac25 or negedge arst_n) begin
        if (!arst_n) begin
            run_sum  <= '0;
            run_mask <= '0;
        end else if (pop_step) begin
            run_sum  <= '0;
            run_mask <= '0;
        end else if (pop_spike) begin
            run_sum  <= run_sum + weight_ext;
            run_mask <= run_mask | idx_bit;
        end
    end

    // result handshake
    always_ff @(posedge clear_mac25 or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (pop_step) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // result payload
    // loaded only on a marker, so it holds while stalled
    always_ff @(posedge clear_mac25) begin
        if (pop_step) begin
            out_sum  <= run_sum;
            out_mask <= run_mask;
        end
    end

endmodule

/* logic/snn_mac_top.sv */
// ====================
// synapse accumulation core top
// ====================
`timescale 1ns/1ps

module snn_mac_top (
    input  logic                               clear_mac25,
    input  logic                               arst_n,
    input  logic                               cfg_valid,
    input  logic [snn_pkg::idx_w-1:0]          cfg_index,
    input  logic [snn_pkg::addr_w-1:0]         cfg_addr,
    input  logic [snn_pkg::weight_w-1:0]       cfg_weight,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [snn_pkg::addr_w-1:0]         in_addr,
    input  logic                               in_step,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic signed [snn_pkg::sum_w-1:0]   out_sum,
    output logic [snn_pkg::n_syn-1:0]          out_mask
);

    // matcher to FIFO
    logic                ev_in_valid;
    logic                ev_in_ready;
    snn_pkg::syn_event_t ev_in;

    // FIFO to accumulator
    logic                ev_out_valid;
    logic                ev_out_ready;
    snn_pkg::syn_event_t ev_out;

    synapse_match u_match (
        .clear_mac25 (clear_mac25),
        .arst_n      (arst_n),
        .cfg_valid   (cfg_valid),
        .cfg_index   (cfg_index),
        .cfg_addr    (cfg_addr),
        .cfg_weight  (cfg_weight),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_addr     (in_addr),
        .in_step     (in_step),
        .ev_valid    (ev_in_valid),
        .ev_ready    (ev_in_ready),
        .ev          (ev_in)
    );

    event_fifo #(
        .DEPTH (snn_pkg::fifo_depth)
    ) u_fifo (
        .clear_mac25 (clear_mac25),
        .arst_n      (arst_n),
        .wr_valid    (ev_in_valid),
        .wr_ready    (ev_in_ready),
        .wr_data     (ev_in),
        .rd_valid    (ev_out_valid),
        .rd_ready    (ev_out_ready),
        .rd_data     (ev_out)
    );

    mac_accum u_accum (
        .clear_mac25 (clear_mac25),
        .arst_n      (arst_n),
        .ev_valid    (ev_out_valid),
        .ev_ready    (ev_out_ready),
        .ev          (ev_out),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_sum     (out_sum),
        .out_mask    (out_mask)
    );

endmodule

/* dv/snn_mac_chk.sv */
// ====================
// protocol assertions for the core,
// bound to snn_mac_top
// ====================
`timescale 1ns/1ps

module snn_mac_chk (
    input logic                                     clear_mac25,
    input logic                                     arst_n,
    input logic                                     in_ready,
    input logic                                     out_valid,
    input logic                                     out_ready,
    input logic signed [snn_pkg::sum_w-1:0]         out_sum,
    input logic [snn_pkg::n_syn-1:0]                out_mask,
    input logic                                     fifo_wr_valid,
    input logic                                     fifo_wr_ready,
    input logic                                     fifo_rd_valid,
    input logic [$clog2(snn_pkg::fifo_depth+1)-1:0] fifo_count
);

    // failure count, watched from the testbench
    int unsigned fail_count = 0;

    // stalled result holds valid and payload
    assert property (@(posedge clear_mac25) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_sum) && $stable(out_mask))
    else begin
        fail_count++;
        $error("result changed while out_ready was low");
    end

    // first cycle out of reset
    assert property (@(posedge clear_mac25) $rose(arst_n) |-> in_ready && !out_valid)
    else begin
        fail_count++;
        $error("wrong handshake state right after reset release");
    end

    // empty FIFO stays silent unless written
    // a write into it shows one cycle later
    assert property (@(posedge clear_mac25) disable iff (!arst_n)
        (fifo_count == '0) |=> (fifo_rd_valid == $past(fifo_wr_valid && fifo_wr_ready)))
    else begin
        fail_count++;
        $error("FIFO read valid wrong after an empty cycle");
    end

endmodule

bind snn_mac_top snn_mac_chk chk (
    .clear_mac25   (clear_mac25),
    .arst_n        (arst_n),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_sum       (out_sum),
    .out_mask      (out_mask),
    .fifo_wr_valid (ev_in_valid),
    .fifo_wr_ready (ev_in_ready),
    .fifo_rd_valid (ev_out_valid),
    .fifo_count    (u_fifo.count)
);

/* dv/snn_mac_tb.sv */
// ====================
// testbench for the synapse accumulation core
// reference model, stimulus, watchdog
// ====================
`timescale 1ns/1ps

module snn_mac_tb;

    // worst-case input beats over all phases
    localparam int max_beats       = 500;
    localparam int watchdog_cycles = max_beats * 50 + 1000;

    logic                             clear_mac25;
    logic                             arst_n;
    logic                             cfg_valid;
    logic [snn_pkg::idx_w-1:0]        cfg_index;
    logic [snn_pkg::addr_w-1:0]       cfg_addr;
    logic [snn_pkg::weight_w-1:0]     cfg_weight;
    logic                             in_valid;
    logic                             in_ready;
    logic [snn_pkg::addr_w-1:0]       in_addr;
    logic                             in_step;
    logic                             out_valid;
    logic                             out_ready = 1'b1;
    logic signed [snn_pkg::sum_w-1:0] out_sum;
    logic [snn_pkg::n_syn-1:0]        out_mask;

    // model copy of the table, open timestep, expected results
    logic [snn_pkg::addr_w-1:0]          tbl_addr [snn_pkg::n_syn];
    logic signed [snn_pkg::weight_w-1:0] tbl_weight [snn_pkg::n_syn];
    logic [snn_pkg::n_syn-1:0]           tbl_en = '0;
    logic [snn_pkg::addr_w-1:0]          step_addrs [$];
    logic signed [snn_pkg::sum_w-1:0]    exp_sum_q [$];
    logic [snn_pkg::n_syn-1:0]           exp_mask_q [$];
    string                               test_name = "reset";
    int                                  stall_cycles = 0;
    logic                                random_bp = 1'b0;
    logic                                saw_stall = 1'b0;

    snn_mac_top uut (.*);

    initial begin
        clear_mac25 = 1'b0;
        forever #2 clear_mac25 = ~clear_mac25;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // lowest enabled index per address, each synapse once
    task automatic close_timestep();
        logic [snn_pkg::n_syn-1:0] mask;
        int                        total;
        logic                      hit;
        mask  = '0;
        total = 0;
        foreach (step_addrs[k]) begin
            hit = 1'b0;
            for (int i = 0; i < snn_pkg::n_syn; i++) begin
                if (!hit && tbl_en[i] && (tbl_addr[i] == step_addrs[k])) begin
                    hit = 1'b1;
                    if (!mask[i]) begin
                        mask[i] = 1'b1;
                        total += int'(tbl_weight[i]);
                    end
                end
            end
        end
        exp_sum_q.push_back(snn_pkg::sum_w'(total));
        exp_mask_q.push_back(mask);
        step_addrs.delete();
    endtask

    task automatic check_result();
        logic signed [snn_pkg::sum_w-1:0] exp_sum;
        logic [snn_pkg::n_syn-1:0]        exp_mask;
        if (exp_sum_q.size() == 0) begin
            fail_now("a result came out with no timestep pending");
        end else begin
            exp_sum  = exp_sum_q.pop_front();
            exp_mask = exp_mask_q.pop_front();
            assert (out_sum == exp_sum) else fail_now($sformatf(
                "[ERROR] %s: sum expected %0d actual %0d", test_name, exp_sum, out_sum));
            assert (out_mask == exp_mask) else fail_now($sformatf(
                "[ERROR] %s: mask expected %b actual %b", test_name, exp_mask, out_mask));
        end
    endtask

    // model update and output compare, on the transfer edge
    always @(posedge clear_mac25) begin
        if (arst_n && in_valid && in_ready) begin
            if (in_step) begin
                close_timestep();
            end else begin
                step_addrs.push_back(in_addr);
            end
        end
        if (arst_n && in_valid && !in_ready) begin
            saw_stall = 1'b1;
        end
        if (arst_n && cfg_valid) begin
            tbl_addr[cfg_index]   = cfg_addr;
            tbl_weight[cfg_index] = cfg_weight;
            tbl_en[cfg_index]     = 1'b1;
        end
        if (arst_n && out_valid && out_ready) begin
            check_result();
        end
    end

    // out_ready: forced stall first, then random or always ready
    always @(negedge clear_mac25) begin
        if (stall_cycles != 0) begin
            out_ready = 1'b0;
            stall_cycles = stall_cycles - 1;
        end else if (random_bp) begin
            out_ready = ($urandom % 3 != 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(negedge clear_mac25) begin
        if (uut.chk.fail_count != 0) begin
            fail_now("a bound protocol assertion failed");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clear_mac25);
        fail_now($sformatf("watchdog: DUT hung, no end after %0d cycles", watchdog_cycles));
    end

    // one beat, random idle gap, waits for acceptance
    task automatic send_beat(input logic [snn_pkg::addr_w-1:0] addr, input logic step);
        @(negedge clear_mac25);
        if ($urandom % 4 == 0) begin
            in_valid = 1'b0;
            @(negedge clear_mac25);
        end
        in_valid = 1'b1;
        in_addr  = addr;
        in_step  = step;
        do begin
            @(posedge clear_mac25);
        end while (!in_ready);
    endtask

    task automatic send_random_step(input int base, input int span);
        for (int k = 0; k < span; k++) begin
            if ($urandom % 2 == 1) begin
                send_beat(snn_pkg::addr_w'(base + k), 1'b0);
            end
        end
        send_beat('0, 1'b1);
    endtask

    task automatic write_cfg(input int idx, input int addr, input logic [15:0] weight);
        @(negedge clear_mac25);
        in_valid   = 1'b0;
        cfg_valid  = 1'b1;
        cfg_index  = snn_pkg::idx_w'(idx);
        cfg_addr   = snn_pkg::addr_w'(addr);
        cfg_weight = weight;
        @(negedge clear_mac25);
        cfg_valid = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clear_mac25);
        in_valid = 1'b0;
        while (exp_sum_q.size() != 0) @(posedge clear_mac25);
    endtask

    initial begin
        void'($urandom(32'ha53c));
        arst_n     = 1'b0;
        cfg_valid  = 1'b0;
        cfg_index  = '0;
        cfg_addr   = '0;
        cfg_weight = '0;
        in_valid   = 1'b0;
        in_addr    = '0;
        in_step    = 1'b0;
        repeat (10) @(posedge clear_mac25);
        @(negedge clear_mac25);
        arst_n = 1'b1;
        @(posedge clear_mac25);
        assert (in_ready && !out_valid) else fail_now($sformatf(
            "[ERROR] %s: in_ready/out_valid expected 1/0 actual %0b/%0b",
            test_name, in_ready, out_valid));
        // table still empty, spikes must sum to zero
        send_beat(12'd13, 1'b0);
        send_beat(12'd14, 1'b0);
        send_beat('0, 1'b1);
        wait_drain();

        test_name = "basic";
        write_cfg(0, 13, 16'h0180);
        write_cfg(1, 14, 16'hff00);
        write_cfg(2, 15, 16'h0240);
        write_cfg(3, 16, 16'hfe80);
        write_cfg(4, 17, 16'h7fff);
        repeat (20) send_random_step(13, 5);
        wait_drain();

        test_name = "filter";
        repeat (3) send_beat(12'd14, 1'b0);
        repeat (2) send_beat(12'd15, 1'b0);
        send_beat('0, 1'b1);
        // sources outside the table
        send_beat(12'd100, 1'b0);
        send_beat(12'd4095, 1'b0);
        send_beat(12'd0, 1'b0);
        send_beat(12'd12, 1'b0);
        send_beat(12'd18, 1'b0);
        send_beat('0, 1'b1);
        send_beat('0, 1'b1);
        wait_drain();

        test_name = "backpressure";
        stall_cycles = 60;
        random_bp    = 1'b1;
        repeat (40) send_random_step(12, 3);
        random_bp = 1'b0;
        wait_drain();

        test_name = "reconfig";
        write_cfg(2, 200, 16'h0300);
        write_cfg(4, 13, 16'h8000);
        write_cfg(1, 14, 16'h0010);
        repeat (10) begin
            if ($urandom % 2 == 1) begin
                send_beat(12'd200, 1'b0);
            end
            send_random_step(13, 5);
        end
        // entry 0 moves away, entry 4 now owns address 13
        write_cfg(0, 300, 16'h0001);
        repeat (10) begin
            if ($urandom % 2 == 1) begin
                send_beat(12'd300, 1'b0);
            end
            send_random_step(13, 5);
        end
        wait_drain();

        test_name = "final";
        assert (saw_stall) else fail_now("in_ready never dropped while the FIFO was full");
        if (uut.chk.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("bound protocol assertions reported failures");
            $display("TEST FAILED");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

/* src.f */
common/snn_pkg.sv
logic/synapse_match.sv
logic/event_fifo.sv
mac/mac_accum.sv
logic/snn_mac_top.sv
dv/snn_mac_chk.sv
dv/snn_mac_tb.sv

/* Makefile */
TOP = snn_mac_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
